// ==== hdl/store_path_pkg.sv ====
`default_nettype none

package store_path_pkg;

    // data word and word address widths
    localparam int unsigned DATA_W = 32;
    localparam int unsigned ADDR_W = 8;

    // write buffer depth, 8 entries
    localparam int unsigned WBUF_AW    = 3;
    localparam int unsigned WBUF_DEPTH = 2 ** WBUF_AW;

    // one buffered whole-word store
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } store_entry_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

endpackage : store_path_pkg

`default_nettype wire

// ==== hdl/write_buffer.sv ====
`default_nettype none

// store FIFO, no coalescing, contents visible for load forwarding
module write_buffer (
    input  wire                                      clk_i,
    input  wire                                      rstn_i,

    // push side
    input  wire                                      we_i,
    input  wire store_path_pkg::store_entry_t        wdata_i,

    // pop side
    input  wire                                      re_i,
    output store_path_pkg::store_entry_t             rdata_o,

    output logic                                     empty_o,
    output logic                                     full_o,

    // forwarding view
    output store_path_pkg::store_entry_t             slots_o [store_path_pkg::WBUF_DEPTH],
    output logic [store_path_pkg::WBUF_DEPTH-1:0]    valid_o,
    output logic [store_path_pkg::WBUF_AW-1:0]       wr_ptr_o
);

    store_path_pkg::store_entry_t mem [store_path_pkg::WBUF_DEPTH];

    // pointers carry an extra wrap bit
    logic [store_path_pkg::WBUF_AW:0]   wr_ptr_q;
    logic [store_path_pkg::WBUF_AW:0]   rd_ptr_q;
    logic [store_path_pkg::WBUF_AW-1:0] wr_idx;
    logic [store_path_pkg::WBUF_AW-1:0] rd_idx;
    logic                               push;
    logic                               pop;
    logic [store_path_pkg::WBUF_DEPTH-1:0] valid_d;
    logic [store_path_pkg::WBUF_DEPTH-1:0] valid_q;

    assign wr_idx = wr_ptr_q[store_path_pkg::WBUF_AW-1:0];
    assign rd_idx = rd_ptr_q[store_path_pkg::WBUF_AW-1:0];

    // same slot index, different lap means full
    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_idx == rd_idx) &&
                     (wr_ptr_q[store_path_pkg::WBUF_AW] != rd_ptr_q[store_path_pkg::WBUF_AW]);

    assign push = we_i & ~full_o;
    assign pop  = re_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_idx] <= wdata_i;
        end
        // head is available the cycle after pop
        if (pop) begin
            rdata_o <= mem[rd_idx];
        end
    end

    // slot valid bits for the forwarding search
    always_comb begin
        valid_d = valid_q;
        if (push) begin
            valid_d[wr_idx] = 1'b1;
        end
        if (pop) begin
            valid_d[rd_idx] = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    assign slots_o  = mem;
    assign valid_o  = valid_q;
    assign wr_ptr_o = wr_idx;

endmodule : write_buffer

`default_nettype wire

// ==== hdl/store_drain.sv ====
`default_nettype none

// empties the write buffer into memory, one word write per entry
module store_drain (
    input  wire                                clk_i,
    input  wire                                rstn_i,

    input  wire                                empty_i,
    output logic                               pop_o,
    input  wire store_path_pkg::store_entry_t  head_i,

    output store_path_pkg::wb_req_t            wb_o,
    input  wire store_path_pkg::wb_rsp_t       wb_i,

    output logic                               inflight_valid_o,
    output store_path_pkg::store_entry_t       inflight_o
);

    typedef enum logic [1:0] {S_IDLE, S_CAPTURE, S_BUS} state_t;

    state_t                       state_q;
    store_path_pkg::store_entry_t entry_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE:    if (!empty_i) state_q <= S_CAPTURE;
                S_CAPTURE: state_q <= S_BUS;
                S_BUS:     if (wb_i.ack) state_q <= S_IDLE;
                default:   state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_CAPTURE) begin
            entry_q <= head_i;
        end
    end

    assign pop_o = (state_q == S_IDLE) & ~empty_i;

    // slot is already invalid during capture, so publish head directly
    assign inflight_valid_o = (state_q != S_IDLE);
    assign inflight_o       = (state_q == S_CAPTURE) ? head_i : entry_q;

    always_comb begin
        wb_o     = '0;
        wb_o.cyc = (state_q == S_BUS);
        wb_o.stb = (state_q == S_BUS);
        wb_o.we  = 1'b1;
        wb_o.adr = entry_q.addr;
        wb_o.dat = entry_q.data;
    end

endmodule : store_drain

`default_nettype wire

// ==== hdl/load_unit.sv ====
`default_nettype none

// word loads with store-to-load forwarding, memory read on a miss
module load_unit (
    input  wire                                     clk_i,
    input  wire                                     rstn_i,

    input  wire                                     ld_valid_i,
    input  wire [store_path_pkg::ADDR_W-1:0]        ld_addr_i,
    output logic                                    ld_ready_o,
    output logic                                    ld_done_o,
    output logic [store_path_pkg::DATA_W-1:0]       ld_data_o,

    // write buffer view
    input  wire store_path_pkg::store_entry_t       slots_i [store_path_pkg::WBUF_DEPTH],
    input  wire [store_path_pkg::WBUF_DEPTH-1:0]    valid_i,
    input  wire [store_path_pkg::WBUF_AW-1:0]       wr_ptr_i,

    // store the drain is writing
    input  wire                                     inflight_valid_i,
    input  wire store_path_pkg::store_entry_t       inflight_i,

    output store_path_pkg::wb_req_t                 wb_o,
    input  wire store_path_pkg::wb_rsp_t            wb_i
);

    typedef enum logic {S_IDLE, S_BUS} state_t;

    state_t                            state_q;
    logic [store_path_pkg::ADDR_W-1:0] addr_q;
    logic [store_path_pkg::DATA_W-1:0] data_q;
    logic                              done_q;
    logic                              accept;
    logic                              fwd_hit;
    logic [store_path_pkg::DATA_W-1:0] fwd_data;
    logic [store_path_pkg::WBUF_AW-1:0] idx;

    assign ld_ready_o = (state_q == S_IDLE);
    assign accept     = ld_valid_i & ld_ready_o;

    // walk back from the write pointer, first match is the youngest
    always_comb begin
        fwd_hit  = 1'b0;
        fwd_data = '0;
        idx      = wr_ptr_i;
        for (int i = 0; i < store_path_pkg::WBUF_DEPTH; i++) begin
            idx = idx - 1'b1;
            if (!fwd_hit && valid_i[idx] && slots_i[idx].addr == ld_addr_i) begin
                fwd_hit  = 1'b1;
                fwd_data = slots_i[idx].data;
            end
        end
        // older than anything still buffered
        if (!fwd_hit && inflight_valid_i && inflight_i.addr == ld_addr_i) begin
            fwd_hit  = 1'b1;
            fwd_data = inflight_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= S_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (accept && fwd_hit) begin
                        done_q <= 1'b1;
                    end else if (accept) begin
                        state_q <= S_BUS;
                    end
                end
                S_BUS: begin
                    if (wb_i.ack) begin
                        done_q  <= 1'b1;
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= ld_addr_i;
            data_q <= fwd_data;
        end else if (state_q == S_BUS && wb_i.ack) begin
            data_q <= wb_i.dat;
        end
    end

    assign ld_done_o = done_q;
    assign ld_data_o = data_q;

    always_comb begin
        wb_o     = '0;
        wb_o.cyc = (state_q == S_BUS);
        wb_o.stb = (state_q == S_BUS);
        wb_o.adr = addr_q;
    end

endmodule : load_unit

`default_nettype wire

// ==== hdl/wb_arbiter.sv ====
`default_nettype none

// two masters onto one wishbone classic slave
// m0 wins when the bus is free, the owner keeps it while its cyc is high
module wb_arbiter (
    input  wire                           clk_i,
    input  wire                           rstn_i,

    input  wire store_path_pkg::wb_req_t  m0_i,
    input  wire store_path_pkg::wb_req_t  m1_i,
    output store_path_pkg::wb_rsp_t       m0_o,
    output store_path_pkg::wb_rsp_t       m1_o,

    output store_path_pkg::wb_req_t       s_o,
    input  wire store_path_pkg::wb_rsp_t  s_i
);

    logic busy_q;
    logic owner_q;
    logic keep;
    logic grant;

    // owner still in its cycle
    assign keep = busy_q & (owner_q ? m1_i.cyc : m0_i.cyc);

    // 0 selects m0, 1 selects m1
    assign grant = keep ? owner_q : ~m0_i.cyc;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
        end else begin
            busy_q  <= m0_i.cyc | m1_i.cyc;
            owner_q <= grant;
        end
    end

    assign s_o = grant ? m1_i : m0_i;

    // only the granted master sees ack
    always_comb begin
        m0_o.dat = s_i.dat;
        m1_o.dat = s_i.dat;
        m0_o.ack = s_i.ack & ~grant;
        m1_o.ack = s_i.ack & grant;
    end

endmodule : wb_arbiter

`default_nettype wire

// ==== hdl/data_mem.sv ====
`default_nettype none

// word memory as a wishbone classic slave, two cycles per access
module data_mem (
    input  wire                           clk_i,
    input  wire                           rstn_i,

    input  wire store_path_pkg::wb_req_t  wb_i,
    output store_path_pkg::wb_rsp_t       wb_o
);

    logic [store_path_pkg::DATA_W-1:0] mem [2 ** store_path_pkg::ADDR_W];

    logic                              ack_q;
    logic [store_path_pkg::DATA_W-1:0] rdata_q;
    logic                              serve;

    // a held request is served once, never back to back acks
    assign serve = wb_i.cyc & wb_i.stb & ~ack_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= serve;
        end
    end

    always_ff @(posedge clk_i) begin
        if (serve) begin
            if (wb_i.we) begin
                mem[wb_i.adr] <= wb_i.dat;
            end
            rdata_q <= mem[wb_i.adr];
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rdata_q;

endmodule : data_mem

`default_nettype wire

// ==== hdl/store_path_top.sv ====
`default_nettype none

module store_path_top (
    input  wire                                 clk_i,
    input  wire                                 rstn_i,

    // store port
    input  wire                                 st_valid_i,
    input  wire store_path_pkg::store_entry_t   st_i,
    output logic                                st_ready_o,

    // load port
    input  wire                                 ld_valid_i,
    input  wire [store_path_pkg::ADDR_W-1:0]    ld_addr_i,
    output logic                                ld_ready_o,
    output logic                                ld_done_o,
    output logic [store_path_pkg::DATA_W-1:0]   ld_data_o
);

    // buffer to drain and load unit
    logic                                  wbuf_empty;
    logic                                  wbuf_full;
    logic                                  wbuf_pop;
    store_path_pkg::store_entry_t          wbuf_head;
    store_path_pkg::store_entry_t          wbuf_slots [store_path_pkg::WBUF_DEPTH];
    logic [store_path_pkg::WBUF_DEPTH-1:0] wbuf_valid;
    logic [store_path_pkg::WBUF_AW-1:0]    wbuf_wr_ptr;

    logic                                  inflight_valid;
    store_path_pkg::store_entry_t          inflight;

    // wishbone, m0 is the load unit and m1 the drain
    store_path_pkg::wb_req_t ld_req;
    store_path_pkg::wb_rsp_t ld_rsp;
    store_path_pkg::wb_req_t dr_req;
    store_path_pkg::wb_rsp_t dr_rsp;
    store_path_pkg::wb_req_t bus_req;
    store_path_pkg::wb_rsp_t bus_rsp;

    assign st_ready_o = ~wbuf_full;

    write_buffer write_buffer_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .we_i     (st_valid_i),
        .wdata_i  (st_i),
        .re_i     (wbuf_pop),
        .rdata_o  (wbuf_head),
        .empty_o  (wbuf_empty),
        .full_o   (wbuf_full),
        .slots_o  (wbuf_slots),
        .valid_o  (wbuf_valid),
        .wr_ptr_o (wbuf_wr_ptr)
    );

    store_drain store_drain_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .empty_i          (wbuf_empty),
        .pop_o            (wbuf_pop),
        .head_i           (wbuf_head),
        .wb_o             (dr_req),
        .wb_i             (dr_rsp),
        .inflight_valid_o (inflight_valid),
        .inflight_o       (inflight)
    );

    load_unit load_unit_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .ld_valid_i       (ld_valid_i),
        .ld_addr_i        (ld_addr_i),
        .ld_ready_o       (ld_ready_o),
        .ld_done_o        (ld_done_o),
        .ld_data_o        (ld_data_o),
        .slots_i          (wbuf_slots),
        .valid_i          (wbuf_valid),
        .wr_ptr_i         (wbuf_wr_ptr),
        .inflight_valid_i (inflight_valid),
        .inflight_i       (inflight),
        .wb_o             (ld_req),
        .wb_i             (ld_rsp)
    );

    wb_arbiter wb_arbiter_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .m0_i   (ld_req),
        .m1_i   (dr_req),
        .m0_o   (ld_rsp),
        .m1_o   (dr_rsp),
        .s_o    (bus_req),
        .s_i    (bus_rsp)
    );

    data_mem data_mem_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .wb_i   (bus_req),
        .wb_o   (bus_rsp)
    );

endmodule : store_path_top

`default_nettype wire

// ==== verification/store_path_assertions.sv ====
`default_nettype none

module store_path_assertions (
    input wire                                   clk_i,
    input wire                                   rstn_i,
    input wire store_path_pkg::wb_req_t          bus_req_i,
    input wire store_path_pkg::wb_rsp_t          bus_rsp_i,
    input wire                                   st_ready_i,
    input wire [store_path_pkg::WBUF_DEPTH-1:0]  wbuf_valid_i,
    input wire                                   ld_valid_i,
    input wire                                   ld_ready_i,
    input wire                                   ld_done_i
);

    timeunit 1ns;
    timeprecision 1ps;

    stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bus_req_i.stb |-> bus_req_i.cyc)
        else $error("slave stb high outside a bus cycle");

    // master holds its request until ack
    req_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (bus_req_i.stb && !bus_rsp_i.ack) |=>
            ($stable(bus_req_i.adr) && $stable(bus_req_i.we) && $stable(bus_req_i.dat)))
        else $error("slave request changed before ack");

    ack_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bus_rsp_i.ack |=> !bus_rsp_i.ack)
        else $error("ack high two cycles in a row");

    // back to back hits give adjacent pulses, one per accepted load
    done_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (ld_done_i && !(ld_valid_i && ld_ready_i)) |=> !ld_done_i)
        else $error("ld_done_o longer than one cycle");

    // a full buffer has every slot valid
    full_slots: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !st_ready_i |-> (&wbuf_valid_i))
        else $error("buffer full with an invalid slot");

endmodule : store_path_assertions

bind store_path_top store_path_assertions store_path_assertions_i (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .bus_req_i    (bus_req),
    .bus_rsp_i    (bus_rsp),
    .st_ready_i   (st_ready_o),
    .wbuf_valid_i (wbuf_valid),
    .ld_valid_i   (ld_valid_i),
    .ld_ready_i   (ld_ready_o),
    .ld_done_i    (ld_done_o)
);

`default_nettype wire

// ==== verification/tb_store_path.sv ====
`default_nettype none

module tb_store_path;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          AW             = store_path_pkg::ADDR_W;
    localparam int          DW             = store_path_pkg::DATA_W;
    localparam int          NUM_ROWS       = 18;
    localparam logic [31:0] SEED           = 32'h449b1c36;
    localparam int          TIMEOUT_MARGIN = 200;

    typedef enum logic [1:0] {OP_STORE, OP_LOAD, OP_IDLE} op_t;
    // expected load latency class
    typedef enum logic [1:0] {LAT_ANY, LAT_HIT, LAT_BUS} lat_t;

    // store rows step the address per repeat, zero data means random data
    typedef struct packed {
        op_t           op;
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        logic [7:0]    reps;
        lat_t          lat;
        logic          full;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{OP_STORE, 8'h10, 32'h1234_5678, 8'd1,  LAT_ANY, 1'b0},
        '{OP_LOAD,  8'h10, 32'h0,         8'd1,  LAT_HIT, 1'b0},
        '{OP_STORE, 8'h20, 32'haaaa_0001, 8'd1,  LAT_ANY, 1'b0},
        '{OP_STORE, 8'h20, 32'hbbbb_0002, 8'd1,  LAT_ANY, 1'b0},
        '{OP_LOAD,  8'h20, 32'h0,         8'd1,  LAT_HIT, 1'b0},
        '{OP_IDLE,  8'h00, 32'h0,         8'd48, LAT_ANY, 1'b0},
        // burst long enough to outrun the drain
        '{OP_STORE, 8'h40, 32'h0,         8'd14, LAT_ANY, 1'b1},
        '{OP_STORE, 8'h40, 32'h0,         8'd4,  LAT_ANY, 1'b0},
        '{OP_LOAD,  8'h40, 32'h0,         8'd14, LAT_ANY, 1'b0},
        '{OP_IDLE,  8'h00, 32'h0,         8'd64, LAT_ANY, 1'b0},
        '{OP_LOAD,  8'h40, 32'h0,         8'd14, LAT_BUS, 1'b0},
        '{OP_LOAD,  8'h10, 32'h0,         8'd1,  LAT_BUS, 1'b0},
        '{OP_LOAD,  8'h20, 32'h0,         8'd1,  LAT_BUS, 1'b0},
        // loads racing the drain
        '{OP_STORE, 8'h80, 32'h0,         8'd6,  LAT_ANY, 1'b0},
        '{OP_LOAD,  8'h80, 32'h0,         8'd6,  LAT_ANY, 1'b0},
        '{OP_STORE, 8'h90, 32'hc0de_0000, 8'd3,  LAT_ANY, 1'b0},
        '{OP_LOAD,  8'h90, 32'h0,         8'd3,  LAT_ANY, 1'b0},
        '{OP_IDLE,  8'h00, 32'h0,         8'd32, LAT_ANY, 1'b0}
    };

    logic                         clk_i = 1'b0;
    logic                         rstn_i;
    logic                         st_valid_i;
    store_path_pkg::store_entry_t st_i;
    logic                         st_ready_o;
    logic                         ld_valid_i;
    logic [AW-1:0]                ld_addr_i;
    logic                         ld_ready_o;
    logic                         ld_done_o;
    logic [DW-1:0]                ld_data_o;

    // reference model, last stored value per word
    logic [DW-1:0] model_mem [2 ** AW];
    bit            model_valid [2 ** AW];
    logic [31:0]   rng_state;
    logic          saw_stall;
    int            errors;
    int            checks;
    int            rows_passed;
    int            rows_failed;

    always #20 clk_i = ~clk_i;

    store_path_top store_path_top_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .st_valid_i (st_valid_i),
        .st_i       (st_i),
        .st_ready_o (st_ready_o),
        .ld_valid_i (ld_valid_i),
        .ld_addr_i  (ld_addr_i),
        .ld_ready_o (ld_ready_o),
        .ld_done_o  (ld_done_o),
        .ld_data_o  (ld_data_o)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic string op_name(input op_t op);
        case (op)
            OP_STORE: return "store";
            OP_LOAD:  return "load";
            default:  return "idle";
        endcase
    endfunction

    // entered and left on a falling edge
    task automatic store_word(input logic [AW-1:0] addr, input logic [DW-1:0] data);
        st_valid_i = 1'b1;
        st_i.addr  = addr;
        st_i.data  = data;
        // full buffer, keep the store presented
        while (!st_ready_o) begin
            saw_stall = 1'b1;
            @(negedge clk_i);
        end
        @(negedge clk_i);
        st_valid_i        = 1'b0;
        model_mem[addr]   = data;
        model_valid[addr] = 1'b1;
    endtask

    task automatic load_word(input logic [AW-1:0] addr, input lat_t lat_kind);
        int            lat;
        logic [DW-1:0] expected;
        ld_valid_i = 1'b1;
        ld_addr_i  = addr;
        while (!ld_ready_o) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
        ld_valid_i = 1'b0;
        lat        = 1;
        while (!ld_done_o) begin
            @(negedge clk_i);
            lat++;
        end
        checks++;
        expected = model_mem[addr];
        assert (model_valid[addr]) else begin
            $display("load at address 0x%02h reads a word that was never stored", addr);
            errors++;
        end
        assert (ld_data_o === expected) else begin
            $display("Error ld_data_o addr 0x%02h expected 0x%08h actual 0x%08h",
                     addr, expected, ld_data_o);
            errors++;
        end
        if (lat_kind == LAT_HIT) begin
            assert (lat == 1) else begin
                $display("load at address 0x%02h took %0d cycles, a forward takes one",
                         addr, lat);
                errors++;
            end
        end else if (lat_kind == LAT_BUS) begin
            assert (lat > 1) else begin
                $display("load at address 0x%02h finished in one cycle, no bus read",
                         addr);
                errors++;
            end
        end
    endtask

    task automatic run_row(input int n, input row_t r);
        int            errors_before;
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        errors_before = errors;
        saw_stall     = 1'b0;
        for (int i = 0; i < int'(r.reps); i++) begin
            addr = r.addr + AW'(i);
            case (r.op)
                OP_STORE: begin
                    if (r.data == '0) begin
                        rng_state = next_random(rng_state);
                        data      = rng_state;
                    end else begin
                        data = r.data + DW'(i);
                    end
                    store_word(addr, data);
                end
                OP_LOAD: begin
                    load_word(addr, r.lat);
                end
                default: begin
                    @(negedge clk_i);
                end
            endcase
        end
        if (r.full) begin
            checks++;
            assert (saw_stall) else begin
                $display("store burst at 0x%02h never saw the buffer full", r.addr);
                errors++;
            end
        end
        if (errors == errors_before) begin
            rows_passed++;
            $display("test %0d %s addr 0x%02h x%0d ok", n, op_name(r.op), r.addr, r.reps);
        end else begin
            rows_failed++;
            $display("test %0d %s addr 0x%02h x%0d failed", n, op_name(r.op), r.addr, r.reps);
        end
    endtask

    initial begin
        rstn_i      = 1'b0;
        st_valid_i  = 1'b0;
        st_i        = '0;
        ld_valid_i  = 1'b0;
        ld_addr_i   = '0;
        rng_state   = SEED;
        saw_stall   = 1'b0;
        errors      = 0;
        checks      = 0;
        rows_passed = 0;
        rows_failed = 0;
        repeat (16) @(negedge clk_i);
        rstn_i = 1'b1;
        @(negedge clk_i);
        checks++;
        assert (st_ready_o && ld_ready_o && !ld_done_o) else begin
            $display("ports not idle after reset, both ready high and done low expected");
            errors++;
        end
        for (int n = 0; n < NUM_ROWS; n++) begin
            run_row(n, ROWS[n]);
        end
        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 NUM_ROWS, rows_passed, rows_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog, eight cycles per table step plus a margin
    initial begin
        int cycles;
        int limit;
        limit = TIMEOUT_MARGIN;
        for (int n = 0; n < NUM_ROWS; n++) begin
            limit += 8 * int'(ROWS[n].reps);
        end
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("run hung, no result after %0d cycles", cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_store_path

`default_nettype wire

// ==== build.f ====
hdl/store_path_pkg.sv
hdl/write_buffer.sv
hdl/store_drain.sv
hdl/load_unit.sv
hdl/wb_arbiter.sv
hdl/data_mem.sv
hdl/store_path_top.sv
verification/store_path_assertions.sv
verification/tb_store_path.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the store path testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_store_path -f build.f -o sim_store_path \
    && ./obj_dir/sim_store_path > sim.log 2>&1 \
    || { echo "build or simulation error, see sim.log"; exit 1; }
grep -q "Simulation passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
